//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_yuv_rgb
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int PERIOD       = 10,
   parameter int RESET_CYCLES = 10
) (
   output logic CLOCK,
   output logic Resetn
);

   initial begin
      CLOCK = 1'b0;
      forever #(PERIOD / 2) CLOCK = ~CLOCK;
   end

   initial begin
      Resetn = 1'b0;
      repeat (RESET_CYCLES) @(posedge CLOCK);
      #1 Resetn = 1'b1; // released just after an edge
   end

endmodule

//--- bench/tb_sram_model.sv
`timescale 1ns/10ps

module tb_sram_model #(
   parameter int DEPTH = 256
) (
   input  logic        CLOCK,
   input  logic [17:0] sram_address,
   input  logic [15:0] sram_write_data,
   input  logic        sram_we_n,
   output logic [15:0] sram_read_data
);
   localparam int AW = $clog2(DEPTH);

   logic [15:0] mem [0:DEPTH-1];
   logic [15:0] read_stage; // first of the two latency stages

   initial begin
      sram_read_data = '0;
      read_stage = '0;
   end

   // address in cycle k gives data during cycle k+2
   always @(posedge CLOCK) begin
      if (!sram_we_n) mem[sram_address[AW-1:0]] = sram_write_data;
      sram_read_data <= #1 read_stage;
      read_stage <= mem[sram_address[AW-1:0]];
   end

endmodule

//--- bench/tb_yuv_rgb.sv
`timescale 1ns/10ps

module tb_yuv_rgb;

   localparam int PAIRS    = 8;
   localparam int U_BASE   = 64;
   localparam int V_BASE   = 96;
   localparam int RGB_BASE = 128;
   localparam int DEPTH    = 256;
   localparam int TIMEOUT_CYCLES = 2 * (12 * PAIRS + 1) + 10 + 50;

   logic CLOCK, Resetn, start, done, sram_we_n;
   logic [17:0] sram_address;
   logic [15:0] sram_write_data, sram_read_data;

   logic [15:0] ref_mem [0:DEPTH-1]; // own copy of the input words
   logic [31:0] lfsr;
   logic ref_busy, exp_done;
   int ref_slot, ref_pair;
   int cycle_count = 0;

   tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(10)) clk_gen (.CLOCK(CLOCK), .Resetn(Resetn));

   tb_sram_model #(.DEPTH(DEPTH)) sram (
      .CLOCK(CLOCK), .sram_address(sram_address), .sram_write_data(sram_write_data),
      .sram_we_n(sram_we_n), .sram_read_data(sram_read_data)
   );

   yuv_rgb_top #(
      .PIXEL_PAIRS(PAIRS), .U_BASE(U_BASE), .V_BASE(V_BASE), .RGB_BASE(RGB_BASE)
   ) dut (
      .CLOCK(CLOCK), .Resetn(Resetn), .start(start), .done(done),
      .sram_address(sram_address), .sram_write_data(sram_write_data),
      .sram_read_data(sram_read_data), .sram_we_n(sram_we_n)
   );

   task automatic abort_run();
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic value_mismatch(input string name, input int expected, input int actual);
      $display("error %s: expected %0h actual %0h", name, expected, actual);
      abort_run();
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw_word(output logic [15:0] word);
      for (int i = 0; i < 16; i++) begin
         word = {word[14:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic store_word(input int addr, input logic [15:0] word);
      sram.mem[addr] = word;
      ref_mem[addr] = word;
   endtask

   task automatic fill_memory(input bit with_extremes);
      logic [15:0] word;
      for (int a = 0; a < DEPTH; a++) begin
         draw_word(word);
         store_word(a, word);
      end
      if (with_extremes) begin
         store_word(2, 16'hffff); // Y 255, V 255
         store_word(V_BASE + 1, 16'hffff);
         store_word(4, 16'h0000); // Y 0, U 0
         store_word(U_BASE + 2, 16'h0000);
         store_word(6, 16'h0000); // Y 0, V 255
         store_word(V_BASE + 3, 16'hffff);
      end
   endtask

   // floor of acc/65536 into 0..255
   function automatic logic [7:0] clamp8(input int acc);
      int q;
      q = acc >>> 16;
      if (q < 0) return 8'd0;
      if (q > 255) return 8'd255;
      return q[7:0];
   endfunction

   function automatic int expected_address(input int k, input int slot);
      case (slot)
         0: return k;
         1: return U_BASE + k / 2;
         2: return V_BASE + k / 2;
         default: return RGB_BASE + 3 * k + slot - 9;
      endcase
   endfunction

   function automatic logic [15:0] expected_word(input int k, input int slot);
      logic [15:0] yw, uw, vw;
      int y_e, y_o, u, v, base_e, base_o;
      logic [7:0] r_e, g_e, b_e, r_o, g_o, b_o;
      yw = ref_mem[k];
      uw = ref_mem[U_BASE + k / 2];
      vw = ref_mem[V_BASE + k / 2];
      y_e = yw[15:8];
      y_o = yw[7:0];
      u = (k % 2 == 1) ? uw[7:0] : uw[15:8];
      v = (k % 2 == 1) ? vw[7:0] : vw[15:8];
      base_e = 76284 * (y_e - 16);
      base_o = 76284 * (y_o - 16);
      r_e = clamp8(base_e + 104595 * (v - 128));
      g_e = clamp8(base_e - 25624 * (u - 128) - 53281 * (v - 128));
      b_e = clamp8(base_e + 132251 * (u - 128));
      r_o = clamp8(base_o + 104595 * (v - 128));
      g_o = clamp8(base_o - 25624 * (u - 128) - 53281 * (v - 128));
      b_o = clamp8(base_o + 132251 * (u - 128));
      case (slot)
         9: return {r_e, g_e};
         10: return {b_e, r_o};
         default: return {g_o, b_o};
      endcase
   endfunction

   // expected schedule, 12 slots per pair, done one cycle after the last
   always @(posedge CLOCK or negedge Resetn) begin
      if (!Resetn) begin
         ref_busy <= 1'b0;
         exp_done <= 1'b0;
         ref_slot <= 0;
         ref_pair <= 0;
      end else begin
         exp_done <= 1'b0;
         if (!ref_busy && !exp_done && start) begin
            ref_busy <= 1'b1;
            ref_slot <= 0;
            ref_pair <= 0;
         end else if (ref_busy && ref_slot == 11) begin
            ref_slot <= 0;
            if (ref_pair == PAIRS - 1) begin
               ref_busy <= 1'b0;
               exp_done <= 1'b1;
            end else begin
               ref_pair <= ref_pair + 1;
            end
         end else if (ref_busy) begin
            ref_slot <= ref_slot + 1;
         end
      end
   end

   a_done: assert property (@(posedge CLOCK) done == exp_done)
      else value_mismatch("done", $sampled(exp_done), $sampled(done));

   a_idle_quiet: assert property (@(posedge CLOCK) !ref_busy |-> sram_we_n)
      else begin
         $display("write strobe active while no pixel pair is in progress");
         abort_run();
      end

   a_strobe: assert property (@(posedge CLOCK) disable iff (!Resetn)
      ref_busy |-> (sram_we_n == (ref_slot < 9)))
      else begin
         $display("write strobe does not follow the read, MAC and write slots");
         abort_run();
      end

   a_address: assert property (@(posedge CLOCK) disable iff (!Resetn)
      (ref_busy && (ref_slot < 3 || ref_slot > 8))
      |-> sram_address == expected_address(ref_pair, ref_slot))
      else value_mismatch("address", expected_address($sampled(ref_pair),
         $sampled(ref_slot)), $sampled(sram_address));

   a_write_data: assert property (@(posedge CLOCK) disable iff (!Resetn)
      (ref_busy && ref_slot > 8) |-> sram_write_data == expected_word(ref_pair, ref_slot))
      else value_mismatch("write_data", expected_word($sampled(ref_pair),
         $sampled(ref_slot)), $sampled(sram_write_data));

   a_write_floor: assert property (@(posedge CLOCK) !sram_we_n |-> sram_address >= RGB_BASE)
      else value_mismatch("write_floor", RGB_BASE, $sampled(sram_address));

   always @(posedge CLOCK) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: both frames not finished within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   task automatic pulse_start();
      @(posedge CLOCK);
      #1 start = 1'b1;
      @(posedge CLOCK);
      #1 start = 1'b0;
   endtask

   task automatic wait_for_done();
      do begin
         @(posedge CLOCK);
         #1;
      end while (done !== 1'b1);
   endtask

   initial begin
      start = 1'b0;
      lfsr = 32'hb4b755b6;
      fill_memory(1'b1);
      @(posedge Resetn);
      pulse_start();
      repeat (20) @(posedge CLOCK);
      #1 start = 1'b1; // mid-frame, must be ignored
      @(posedge CLOCK);
      #1 start = 1'b0;
      wait_for_done();
      fill_memory(1'b0); // second frame on fresh data
      pulse_start();
      wait_for_done();
      $display("Testbench passed");
      $finish;
   end

endmodule

//--- hw/csc_mac_unit.sv
`timescale 1ns/10ps

module csc_mac_unit (
   input  logic                                  CLOCK,
   input  logic                                  Resetn,
   input  logic [yuv_rgb_pkg::DATA_W-1:0]        sram_read_data,
   input  logic                                  cap_y,
   input  logic                                  cap_u,
   input  logic                                  cap_v,
   input  logic                                  pair_odd,
   input  yuv_rgb_pkg::mac_op_t                  mac_op,
   output logic signed [yuv_rgb_pkg::ACC_W-1:0]  acc_r_even,
   output logic signed [yuv_rgb_pkg::ACC_W-1:0]  acc_r_odd,
   output logic signed [yuv_rgb_pkg::ACC_W-1:0]  acc_g_even,
   output logic signed [yuv_rgb_pkg::ACC_W-1:0]  acc_g_odd,
   output logic signed [yuv_rgb_pkg::ACC_W-1:0]  acc_b_even,
   output logic signed [yuv_rgb_pkg::ACC_W-1:0]  acc_b_odd
);
   import yuv_rgb_pkg::*;

   logic [DATA_W-1:0] y_word; // even pixel in the high byte
   logic [PIX_W-1:0] u_byte, v_byte;
   logic signed [ACC_W-1:0] coef;
   logic signed [ACC_W-1:0] op_even, op_odd;
   logic signed [ACC_W-1:0] prod_even, prod_odd;
   logic signed [ACC_W-1:0] u_term, v_term;

   always_ff @(posedge CLOCK) begin
      if (cap_y) y_word <= sram_read_data;
      if (cap_u) u_byte <= pair_odd ? sram_read_data[7:0] : sram_read_data[15:8];
      if (cap_v) v_byte <= pair_odd ? sram_read_data[7:0] : sram_read_data[15:8];
   end

   assign u_term = $signed({{(ACC_W-PIX_W){1'b0}}, u_byte}) - C_OFFSET;
   assign v_term = $signed({{(ACC_W-PIX_W){1'b0}}, v_byte}) - C_OFFSET;

   // operand select, chroma shared by both pixels
   always_comb begin
      coef = '0;
      op_even = '0;
      op_odd = '0;
      case (mac_op)
         MAC_LOAD_Y: begin
            coef = COEF_Y;
            op_even = $signed({{(ACC_W-PIX_W){1'b0}}, y_word[15:8]}) - Y_OFFSET;
            op_odd = $signed({{(ACC_W-PIX_W){1'b0}}, y_word[7:0]}) - Y_OFFSET;
         end
         MAC_ADD_BU, MAC_SUB_GU: begin
            coef = (mac_op == MAC_ADD_BU) ? COEF_BU : COEF_GU;
            op_even = u_term;
            op_odd = u_term;
         end
         MAC_ADD_RV, MAC_SUB_GV: begin
            coef = (mac_op == MAC_ADD_RV) ? COEF_RV : COEF_GV;
            op_even = v_term;
            op_odd = v_term;
         end
         default: ;
      endcase
   end

   assign prod_even = coef * op_even;
   assign prod_odd = coef * op_odd;

   always_ff @(posedge CLOCK) begin
      case (mac_op)
         MAC_LOAD_Y: begin // luma base into every channel
            acc_r_even <= prod_even;
            acc_g_even <= prod_even;
            acc_b_even <= prod_even;
            acc_r_odd <= prod_odd;
            acc_g_odd <= prod_odd;
            acc_b_odd <= prod_odd;
         end
         MAC_ADD_BU: begin
            acc_b_even <= acc_b_even + prod_even;
            acc_b_odd <= acc_b_odd + prod_odd;
         end
         MAC_SUB_GU, MAC_SUB_GV: begin
            acc_g_even <= acc_g_even - prod_even;
            acc_g_odd <= acc_g_odd - prod_odd;
         end
         MAC_ADD_RV: begin
            acc_r_even <= acc_r_even + prod_even;
            acc_r_odd <= acc_r_odd + prod_odd;
         end
         default: ;
      endcase
   end

   a_op_known: assert property (@(posedge CLOCK) disable iff (!Resetn)
      !$isunknown(mac_op));

endmodule

//--- hw/csc_sequencer.sv
`timescale 1ns/10ps

module csc_sequencer (
   input  logic                   CLOCK,
   input  logic                   Resetn,
   input  logic                   start,
   input  logic                   last_pair,
   output logic                   done,
   output yuv_rgb_pkg::addr_sel_t addr_sel,
   output yuv_rgb_pkg::mac_op_t   mac_op,
   output logic                   cap_y,
   output logic                   cap_u,
   output logic                   cap_v,
   output logic                   clip_load,
   output logic [1:0]             wr_slot,
   output logic                   write_active,
   output logic                   pair_step,
   output logic                   frame_clear
);
   import yuv_rgb_pkg::*;

   csc_state_t state, next_state;

   always_ff @(posedge CLOCK or negedge Resetn) begin
      if (!Resetn) begin
         state <= IDLE;
         done <= 1'b0;
      end else begin
         state <= next_state;
         done <= (state == WR_2) && last_pair; // single pulse on the way back to IDLE
      end
   end

   // fixed 12-cycle schedule per pair
   always_comb begin
      next_state = state;
      case (state)
         IDLE:    if (start && !done) next_state = RD_Y; // done cycle still busy
         RD_Y:    next_state = RD_U;
         RD_U:    next_state = RD_V;
         RD_V:    next_state = MAC_Y;
         MAC_Y:   next_state = MAC_BU;
         MAC_BU:  next_state = MAC_GU;
         MAC_GU:  next_state = MAC_RV;
         MAC_RV:  next_state = MAC_GV;
         MAC_GV:  next_state = CLIP;
         CLIP:    next_state = WR_0;
         WR_0:    next_state = WR_1;
         WR_1:    next_state = WR_2;
         WR_2:    next_state = last_pair ? IDLE : RD_Y;
         default: next_state = IDLE;
      endcase
   end

   always_comb begin
      case (state)
         RD_U:             addr_sel = SEL_U;
         RD_V:             addr_sel = SEL_V;
         WR_0, WR_1, WR_2: addr_sel = SEL_RGB;
         default:          addr_sel = SEL_Y;
      endcase
   end

   always_comb begin
      case (state)
         MAC_Y:   mac_op = MAC_LOAD_Y;
         MAC_BU:  mac_op = MAC_ADD_BU;
         MAC_GU:  mac_op = MAC_SUB_GU;
         MAC_RV:  mac_op = MAC_ADD_RV;
         MAC_GV:  mac_op = MAC_SUB_GV;
         default: mac_op = MAC_NONE;
      endcase
   end

   // read data lands two cycles after its address
   assign cap_y = (state == RD_V);
   assign cap_u = (state == MAC_Y);
   assign cap_v = (state == MAC_BU);
   assign clip_load = (state == CLIP);

   assign wr_slot = (state == WR_1) ? 2'd1 : (state == WR_2) ? 2'd2 : 2'd0;
   assign write_active = (state == WR_0) || (state == WR_1) || (state == WR_2);
   assign pair_step = (state == WR_2);
   assign frame_clear = (state == IDLE) && start && !done;

   a_done_pulse: assert property (@(posedge CLOCK) disable iff (!Resetn)
      done |=> (state == IDLE) && !done);

   // write slots step through 0 to 2 in back-to-back cycles and then stop
   a_write_slot: assert property (@(posedge CLOCK) disable iff (!Resetn)
      write_active |=> ($past(wr_slot) < 2'd2)
         ? (write_active && (wr_slot == $past(wr_slot) + 2'd1)) : !write_active);

endmodule

//--- hw/pair_address_counter.sv
`timescale 1ns/10ps

module pair_address_counter #(
   parameter int PIXEL_PAIRS = 38400,
   parameter int U_BASE      = 38400,
   parameter int V_BASE      = 57600,
   parameter int RGB_BASE    = 146944
) (
   input  logic                           CLOCK,
   input  logic                           Resetn,
   input  logic                           frame_clear,
   input  logic                           pair_step,
   input  yuv_rgb_pkg::addr_sel_t         addr_sel,
   input  logic [1:0]                     wr_slot,
   output logic [yuv_rgb_pkg::ADDR_W-1:0] sram_address,
   output logic                           pair_odd,
   output logic                           last_pair
);
   import yuv_rgb_pkg::*;

   logic [ADDR_W-1:0] pair_idx; // also the Y word address
   logic [ADDR_W-1:0] rgb_ptr;  // first write word of this pair
   logic [ADDR_W-1:0] chroma_idx;

   always_ff @(posedge CLOCK or negedge Resetn) begin
      if (!Resetn) begin
         pair_idx <= '0;
         rgb_ptr <= ADDR_W'(RGB_BASE);
      end else if (frame_clear) begin
         pair_idx <= '0;
         rgb_ptr <= ADDR_W'(RGB_BASE);
      end else if (pair_step) begin
         pair_idx <= last_pair ? '0 : pair_idx + 1'b1;
         rgb_ptr <= rgb_ptr + ADDR_W'(3); // three words per pair
      end
   end

   assign last_pair = (pair_idx == ADDR_W'(PIXEL_PAIRS - 1));
   assign pair_odd = pair_idx[0];
   assign chroma_idx = {1'b0, pair_idx[ADDR_W-1:1]}; // one U/V word serves two pairs

   always_comb begin
      case (addr_sel)
         SEL_U:   sram_address = ADDR_W'(U_BASE) + chroma_idx;
         SEL_V:   sram_address = ADDR_W'(V_BASE) + chroma_idx;
         SEL_RGB: sram_address = rgb_ptr + ADDR_W'(wr_slot);
         default: sram_address = pair_idx;
      endcase
   end

   a_pair_range: assert property (@(posedge CLOCK) disable iff (!Resetn)
      pair_idx < ADDR_W'(PIXEL_PAIRS));

endmodule

//--- hw/rgb_clip_pack.sv
`timescale 1ns/10ps

module rgb_clip_pack (
   input  logic                                 CLOCK,
   input  logic                                 Resetn,
   input  logic                                 clip_load,
   input  logic [1:0]                           wr_slot,
   input  logic signed [yuv_rgb_pkg::ACC_W-1:0] acc_r_even,
   input  logic signed [yuv_rgb_pkg::ACC_W-1:0] acc_r_odd,
   input  logic signed [yuv_rgb_pkg::ACC_W-1:0] acc_g_even,
   input  logic signed [yuv_rgb_pkg::ACC_W-1:0] acc_g_odd,
   input  logic signed [yuv_rgb_pkg::ACC_W-1:0] acc_b_even,
   input  logic signed [yuv_rgb_pkg::ACC_W-1:0] acc_b_odd,
   output logic [yuv_rgb_pkg::DATA_W-1:0]       sram_write_data
);
   import yuv_rgb_pkg::*;

   logic [PIX_W-1:0] r_even, r_odd, g_even, g_odd, b_even, b_odd;

   // floor of acc/65536, clamped to 0..255
   function automatic logic [PIX_W-1:0] clip8(input logic signed [ACC_W-1:0] acc);
      if (acc[ACC_W-1]) return '0;
      else if (|acc[ACC_W-2:24]) return '1;
      else return acc[23:16];
   endfunction

   always_ff @(posedge CLOCK or negedge Resetn) begin
      if (!Resetn) begin
         {r_even, r_odd, g_even, g_odd, b_even, b_odd} <= '0;
      end else if (clip_load) begin
         r_even <= clip8(acc_r_even);
         r_odd <= clip8(acc_r_odd);
         g_even <= clip8(acc_g_even);
         g_odd <= clip8(acc_g_odd);
         b_even <= clip8(acc_b_even);
         b_odd <= clip8(acc_b_odd);
      end
   end

   always_comb begin
      case (wr_slot)
         2'd0:    sram_write_data = {r_even, g_even};
         2'd1:    sram_write_data = {b_even, r_odd};
         default: sram_write_data = {g_odd, b_odd}; // last word of the pair
      endcase
   end

endmodule

//--- hw/yuv_rgb_pkg.sv
package yuv_rgb_pkg;

   localparam int ADDR_W = 18; // sram address
   localparam int DATA_W = 16; // sram word
   localparam int PIX_W  = 8;
   localparam int ACC_W  = 32;

   // offsets removed before the multiply
   localparam logic signed [ACC_W-1:0] Y_OFFSET = 32'sd16;
   localparam logic signed [ACC_W-1:0] C_OFFSET = 32'sd128;

   // 16.16 fixed point
   localparam logic signed [ACC_W-1:0] COEF_Y  = 32'sd76284;
   localparam logic signed [ACC_W-1:0] COEF_RV = 32'sd104595;
   localparam logic signed [ACC_W-1:0] COEF_GU = 32'sd25624;
   localparam logic signed [ACC_W-1:0] COEF_GV = 32'sd53281;
   localparam logic signed [ACC_W-1:0] COEF_BU = 32'sd132251;

   typedef enum logic [3:0] {
      IDLE,
      RD_Y,
      RD_U,
      RD_V,
      MAC_Y,
      MAC_BU,
      MAC_GU,
      MAC_RV,
      MAC_GV,
      CLIP,
      WR_0,
      WR_1,
      WR_2
   } csc_state_t;

   typedef enum logic [2:0] {
      MAC_NONE,
      MAC_LOAD_Y,
      MAC_ADD_BU,
      MAC_SUB_GU,
      MAC_ADD_RV,
      MAC_SUB_GV
   } mac_op_t;

   typedef enum logic [1:0] {SEL_Y, SEL_U, SEL_V, SEL_RGB} addr_sel_t;

endpackage

//--- hw/yuv_rgb_top.sv
`timescale 1ns/10ps

module yuv_rgb_top #(
   parameter int PIXEL_PAIRS = 38400, // must be even
   parameter int U_BASE      = 38400,
   parameter int V_BASE      = 57600,
   parameter int RGB_BASE    = 146944
) (
   input  logic                             CLOCK,
   input  logic                             Resetn,
   input  logic                             start,
   output logic                             done,
   output logic [yuv_rgb_pkg::ADDR_W-1:0]   sram_address,
   output logic [yuv_rgb_pkg::DATA_W-1:0]   sram_write_data,
   input  logic [yuv_rgb_pkg::DATA_W-1:0]   sram_read_data,
   output logic                             sram_we_n
);
   import yuv_rgb_pkg::*;

   addr_sel_t addr_sel;
   mac_op_t mac_op;
   logic cap_y, cap_u, cap_v;
   logic clip_load;
   logic [1:0] wr_slot;
   logic write_active;
   logic pair_step, frame_clear;
   logic last_pair, pair_odd;
   logic signed [ACC_W-1:0] acc_r_even, acc_r_odd;
   logic signed [ACC_W-1:0] acc_g_even, acc_g_odd;
   logic signed [ACC_W-1:0] acc_b_even, acc_b_odd;

   assign sram_we_n = ~write_active; // write strobe is active low

   csc_sequencer u_seq (
      .CLOCK(CLOCK), .Resetn(Resetn), .start(start), .last_pair(last_pair),
      .done(done), .addr_sel(addr_sel), .mac_op(mac_op),
      .cap_y(cap_y), .cap_u(cap_u), .cap_v(cap_v),
      .clip_load(clip_load), .wr_slot(wr_slot), .write_active(write_active),
      .pair_step(pair_step), .frame_clear(frame_clear)
   );

   pair_address_counter #(
      .PIXEL_PAIRS(PIXEL_PAIRS), .U_BASE(U_BASE), .V_BASE(V_BASE), .RGB_BASE(RGB_BASE)
   ) u_cnt (
      .CLOCK(CLOCK), .Resetn(Resetn), .frame_clear(frame_clear), .pair_step(pair_step),
      .addr_sel(addr_sel), .wr_slot(wr_slot),
      .sram_address(sram_address), .pair_odd(pair_odd), .last_pair(last_pair)
   );

   csc_mac_unit u_mac (
      .CLOCK(CLOCK), .Resetn(Resetn), .sram_read_data(sram_read_data),
      .cap_y(cap_y), .cap_u(cap_u), .cap_v(cap_v), .pair_odd(pair_odd), .mac_op(mac_op),
      .acc_r_even(acc_r_even), .acc_r_odd(acc_r_odd),
      .acc_g_even(acc_g_even), .acc_g_odd(acc_g_odd),
      .acc_b_even(acc_b_even), .acc_b_odd(acc_b_odd)
   );

   rgb_clip_pack u_pack (
      .CLOCK(CLOCK), .Resetn(Resetn), .clip_load(clip_load), .wr_slot(wr_slot),
      .acc_r_even(acc_r_even), .acc_r_odd(acc_r_odd),
      .acc_g_even(acc_g_even), .acc_g_odd(acc_g_odd),
      .acc_b_even(acc_b_even), .acc_b_odd(acc_b_odd),
      .sram_write_data(sram_write_data)
   );

endmodule

//--- verilog.f
hw/yuv_rgb_pkg.sv
hw/csc_sequencer.sv
hw/pair_address_counter.sv
hw/csc_mac_unit.sv
hw/rgb_clip_pack.sv
hw/yuv_rgb_top.sv
bench/tb_clock_gen.sv
bench/tb_sram_model.sv
bench/tb_yuv_rgb.sv
